/* Makefile */
# Verilator build for the video memory testbench

VERILATOR ?= verilator
TOP ?= tb_video_mem
RTL_TOP ?= video_mem
FLIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
hw/video_pkg.sv
hw/line_ram.sv
hw/hdmi_scaler.sv
hw/row_sync.sv
hw/lcd_reader.sv
hw/video_mem.sv
testbench/tb_video_mem.sv

/* hw/hdmi_scaler.sv */
// ====================================================================
// HDMI address generator
// Scales the 640x480 raster fetches down onto the stored 480x320
// picture by dropping one fetch in four and one line in three
// ====================================================================

module hdmi_scaler #(
	parameter int addr_width = 11
) (
	input logic pixel_clk,
	input logic reset,
	input logic fetch_next,
	input logic next_line,
	input logic next_field,
	output logic [addr_width-1:0] video_addr
);
	import video_pkg::*;

	localparam int row_bits = addr_width - col_bits;
	localparam int x_cnt_w = $clog2(x_period);
	localparam int y_cnt_w = $clog2(y_period);

	// Sized copies of the package constants for the compares below
	localparam logic [x_cnt_w-1:0] x_last = x_cnt_w'(x_period - 1);
	localparam logic [x_cnt_w-1:0] x_kept = x_cnt_w'(x_keep);
	localparam logic [y_cnt_w-1:0] y_last = y_cnt_w'(y_period - 1);
	localparam logic [y_cnt_w-1:0] y_kept = y_cnt_w'(y_keep);
	localparam logic [col_bits-1:0] col_last = col_bits'(lcd_width - 1);
	localparam logic [line_cnt_w-1:0] line_last = line_cnt_w'(lcd_height - 1);

	// Reset arrives from the clk domain
	logic reset_meta;
	logic reset_pix;

	// Position in the stored picture
	logic [row_bits-1:0] row;
	logic [col_bits-1:0] col;

	// Phase within the horizontal and vertical cadences
	logic [x_cnt_w-1:0] x_cnt;
	logic [y_cnt_w-1:0] y_cnt;

	// Rows stepped so far in this field
	logic [line_cnt_w-1:0] line_cnt;

	// Two flops bring the reset into the pixel clock domain,
	// so this side leaves reset two pixel_clk edges after clk does
	always_ff @(posedge pixel_clk) begin
		reset_meta <= reset;
		reset_pix <= reset_meta;
	end

	// Strobe priority is next_field, then next_line, then fetch_next
	always_ff @(posedge pixel_clk) begin
		if (reset_pix || next_field) begin
			row <= '0;
			col <= '0;
			x_cnt <= '0;
			y_cnt <= '0;
			line_cnt <= '0;
		end else if (next_line) begin
			// Every line restarts at the left edge
			col <= '0;
			x_cnt <= '0;
			y_cnt <= (y_cnt == y_last) ? '0 : y_cnt + 1'b1;
			// Lines in the kept part of the cadence step to the next row,
			// and the row stops once the last stored row is reached
			if (y_cnt < y_kept && line_cnt != line_last) begin
				row <= row + 1'b1;
				line_cnt <= line_cnt + 1'b1;
			end
		end else if (fetch_next) begin
			x_cnt <= (x_cnt == x_last) ? '0 : x_cnt + 1'b1;
			// The dropped fetch repeats the previous pixel on screen
			// Column holds at the right edge for the tail of the raster line
			if (x_cnt < x_kept && col != col_last) begin
				col <= col + 1'b1;
			end
		end
	end

	assign video_addr = {row, col};

	// Column stays inside the 480 stored pixels of a row
	a_col_in_row : assert property (
		@(posedge pixel_clk) disable iff (reset_pix)
		col <= col_last
	) else begin
		$error("hdmi_scaler: column %h past the end of the row", col);
	end

endmodule

/* hw/lcd_reader.sv */
// ====================================================================
// LCD address walker
// Steps through the 480x320 picture one pixel per request, holds
// back at the row the HDMI side is showing and flags each new field
// ====================================================================

module lcd_reader #(
	parameter int addr_width = 11
) (
	input logic clk,
	input logic reset,
	input logic lcd_next_pixel,
	input logic [addr_width-video_pkg::col_bits-1:0] cur_row,
	output logic [addr_width-1:0] lcd_addr,
	output logic lcd_wait,
	output logic lcd_newfield
);
	import video_pkg::*;

	localparam int row_bits = addr_width - col_bits;
	localparam logic [col_bits-1:0] col_last = col_bits'(lcd_width - 1);
	localparam logic [line_cnt_w-1:0] line_last = line_cnt_w'(lcd_height - 1);

	// Position in the ring of rows
	logic [row_bits-1:0] row;
	logic [col_bits-1:0] col;

	// Rows finished in this field, independent of where the ring wraps
	logic [line_cnt_w-1:0] line_cnt;

	// At the end of the row HDMI is reading, so the next row is not ready
	logic at_hold;

	// A request is taken only when neither the live nor the registered hold is set
	logic accept;

	assign at_hold = (row == cur_row) && (col == col_last);
	assign accept = lcd_next_pixel && !at_hold && !lcd_wait;

	always_ff @(posedge clk) begin
		if (reset) begin
			row <= '0;
			col <= '0;
			line_cnt <= '0;
			lcd_wait <= 1'b0;
			lcd_newfield <= 1'b0;
		end else begin
			lcd_wait <= at_hold;
			// New-field flag lasts a single cycle
			lcd_newfield <= 1'b0;
			if (accept) begin
				if (col == col_last) begin
					col <= '0;
					if (line_cnt == line_last) begin
						// Last pixel of the field, start over at address zero
						row <= '0;
						line_cnt <= '0;
						lcd_newfield <= 1'b1;
					end else begin
						// Row number wraps around the ring by itself
						row <= row + 1'b1;
						line_cnt <= line_cnt + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	assign lcd_addr = {row, col};

	// While the LCD is told to wait, its address and so its pixel stay put
	a_hold_addr : assert property (
		@(posedge clk) disable iff (reset)
		lcd_wait |=> $stable(lcd_addr)
	) else begin
		$error("lcd_reader: address moved to %h while waiting", lcd_addr);
	end

endmodule

/* hw/line_ram.sv */
// ====================================================================
// Dual-clock line RAM
// Port A writes or reads on clk_a, port B reads on its own clock
// ====================================================================

module line_ram #(
	parameter int addr_width = 11
) (
	input logic clk_a,
	input logic [addr_width-1:0] addr_a,
	input logic [video_pkg::pixel_w-1:0] wdata_a,
	input logic we_a,
	input logic re_a,
	output logic [video_pkg::pixel_w-1:0] rdata_a,

	input logic clk_b,
	input logic [addr_width-1:0] addr_b,
	output logic [video_pkg::pixel_w-1:0] rdata_b
);
	import video_pkg::*;

	localparam int depth = 2 ** addr_width;

	// One word per pixel, rows of 512 words laid end to end
	logic [pixel_w-1:0] mem [depth];

	// CPU port
	// A write takes the cycle; otherwise a read enable loads the output register
	// The output keeps the last word read until the next read
	always_ff @(posedge clk_a) begin
		if (we_a) begin
			mem[addr_a] <= wdata_a;
		end else if (re_a) begin
			rdata_a <= mem[addr_a];
		end
	end

	// Display port
	// Reads on every edge so the pixel follows the address one cycle later
	always_ff @(posedge clk_b) begin
		rdata_b <= mem[addr_b];
	end

	// The CPU side issues either a read or a write in a cycle, never both,
	// otherwise the read would be dropped and data_out would go stale
	a_no_read_write : assert property (
		@(posedge clk_a)
		!$isunknown({we_a, re_a}) |-> !(we_a && re_a)
	) else begin
		$error("line_ram: read and write on port A in one cycle, addr %h", addr_a);
	end

endmodule

/* hw/row_sync.sv */
// ====================================================================
// HDMI row crossing
// Carries the current HDMI row into the clk domain as Gray code,
// and the field start as a toggle turned into a one-clk pulse
// ====================================================================

module row_sync #(
	parameter int addr_width = 11
) (
	input logic pixel_clk,
	input logic clk,
	input logic [addr_width-1:0] video_addr,
	input logic next_field,
	output logic [addr_width-video_pkg::col_bits-1:0] cur_row,
	output logic field_start
);
	import video_pkg::*;

	localparam int row_bits = addr_width - col_bits;

	function automatic logic [row_bits-1:0] gray_to_bin(input logic [row_bits-1:0] gray);
		logic [row_bits-1:0] bin;
		bin[row_bits-1] = gray[row_bits-1];
		// Each binary bit is the XOR of all Gray bits at and above it
		for (int i = row_bits - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

	// Pixel clock side
	logic [row_bits-1:0] pix_row;
	logic [row_bits-1:0] gray_pix = '0;
	logic field_tgl = 1'b0;

	// Clk side
	logic [row_bits-1:0] gray_meta = '0;
	logic [row_bits-1:0] gray_sync = '0;
	logic tgl_meta = 1'b0;
	logic tgl_sync = 1'b0;
	logic tgl_last = 1'b0;
	logic start_q = 1'b0;

	assign pix_row = video_addr[addr_width-1:col_bits];

	// Row steps are single increments, so registered Gray code moves one
	// bit at a time and any sample on the clk side is a valid row
	always_ff @(posedge pixel_clk) begin
		gray_pix <= pix_row ^ (pix_row >> 1);
		if (next_field) begin
			field_tgl <= ~field_tgl;
		end
	end

	// Two flops per crossing, then edge detect on the toggle
	always_ff @(posedge clk) begin
		gray_meta <= gray_pix;
		gray_sync <= gray_meta;
		tgl_meta <= field_tgl;
		tgl_sync <= tgl_meta;
		tgl_last <= tgl_sync;
		start_q <= tgl_sync ^ tgl_last;
	end

	assign cur_row = gray_to_bin(gray_sync);
	assign field_start = start_q;

	// Only the jump back to row zero at a field start may move more than
	// one Gray bit; the toggle path flags that case to the clk side
	a_gray_one_bit : assert property (
		@(posedge pixel_clk)
		(!$isunknown({gray_pix, $past(gray_pix)}) && !$past(next_field, 2))
			|-> ($countones(gray_pix ^ $past(gray_pix)) <= 1)
	) else begin
		$error("row_sync: Gray row jumped from %h to %h", $past(gray_pix), gray_pix);
	end

endmodule

/* hw/video_mem.sv */
// ====================================================================
// Dual-display video memory
// CPU port on clk writes both RAM copies; one copy feeds the scaled
// HDMI side on pixel_clk, the other feeds the LCD side on clk
// ====================================================================

module video_mem #(
	// Must be at least 10 so the ring holds more than one row
	parameter int addr_width = 11
) (
	input logic clk,
	input logic reset,
	input logic pixel_clk,

	input logic [addr_width-1:0] addr,
	input logic [video_pkg::pixel_w-1:0] data_in,
	input logic wen,
	input logic ren,
	output logic [video_pkg::pixel_w-1:0] data_out,

	input logic lcd_next_pixel,
	output logic lcd_newfield,
	output logic lcd_wait,
	output logic [video_pkg::color_w-1:0] lcd_red,
	output logic [video_pkg::color_w-1:0] lcd_green,
	output logic [video_pkg::color_w-1:0] lcd_blue,

	input logic fetch_next,
	input logic next_line,
	input logic next_field,
	output logic [video_pkg::color_w-1:0] red,
	output logic [video_pkg::color_w-1:0] green,
	output logic [video_pkg::color_w-1:0] blue
);
	import video_pkg::*;

	// Read addresses of the two display sides
	logic [addr_width-1:0] video_addr;
	logic [addr_width-1:0] lcd_addr;

	// Pixels as read from each copy
	logic [pixel_w-1:0] hdmi_pixel;
	logic [pixel_w-1:0] lcd_pixel;

	// HDMI row seen from the clk domain
	logic [addr_width-col_bits-1:0] cur_row;

	// HDMI copy also serves CPU reads
	line_ram #(.addr_width(addr_width)) ram_hdmi (
		.clk_a(clk),
		.addr_a(addr),
		.wdata_a(data_in),
		.we_a(wen),
		.re_a(ren),
		.rdata_a(data_out),
		.clk_b(pixel_clk),
		.addr_b(video_addr),
		.rdata_b(hdmi_pixel)
	);

	// LCD copy is written only, its port B runs on clk
	line_ram #(.addr_width(addr_width)) ram_lcd (
		.clk_a(clk),
		.addr_a(addr),
		.wdata_a(data_in),
		.we_a(wen),
		.re_a(1'b0),
		.rdata_a(),
		.clk_b(clk),
		.addr_b(lcd_addr),
		.rdata_b(lcd_pixel)
	);

	hdmi_scaler #(.addr_width(addr_width)) u_hdmi_scaler (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.fetch_next(fetch_next),
		.next_line(next_line),
		.next_field(next_field),
		.video_addr(video_addr)
	);

	row_sync #(.addr_width(addr_width)) u_row_sync (
		.pixel_clk(pixel_clk),
		.clk(clk),
		.video_addr(video_addr),
		.next_field(next_field),
		.cur_row(cur_row),
		.field_start()
	);

	lcd_reader #(.addr_width(addr_width)) u_lcd_reader (
		.clk(clk),
		.reset(reset),
		.lcd_next_pixel(lcd_next_pixel),
		.cur_row(cur_row),
		.lcd_addr(lcd_addr),
		.lcd_wait(lcd_wait),
		.lcd_newfield(lcd_newfield)
	);

	// Split the stored words into colour bytes
	assign red = hdmi_pixel[red_lo +: color_w];
	assign green = hdmi_pixel[green_lo +: color_w];
	assign blue = hdmi_pixel[blue_lo +: color_w];

	assign lcd_red = lcd_pixel[red_lo +: color_w];
	assign lcd_green = lcd_pixel[green_lo +: color_w];
	assign lcd_blue = lcd_pixel[blue_lo +: color_w];

endmodule

/* hw/video_pkg.sv */
// ====================================================================
// Video line memory shared definitions
// Address split, stored picture size, HDMI scaling cadences and the
// byte positions of the colours inside a stored pixel
// ====================================================================

package video_pkg;

	// Low address bits select the column, the rest select the row in the ring
	localparam int col_bits = 9;

	// Stored picture, which is also the LCD panel size
	localparam int lcd_width = 480;
	localparam int lcd_height = 320;

	// Width of the counter that tracks the rows of one field
	localparam int line_cnt_w = $clog2(lcd_height);

	// Horizontal cadence: 640 fetches map onto 480 columns
	// Three fetches out of every four advance the column
	localparam int x_period = 4;
	localparam int x_keep = 3;

	// Vertical cadence: 480 lines map onto 320 rows
	// Two lines out of every three advance the row
	localparam int y_period = 3;
	localparam int y_keep = 2;

	// Stored pixel is three colour bytes
	localparam int pixel_w = 24;
	localparam int color_w = 8;

	// Red sits in the low byte and blue in the high byte
	localparam int red_lo = 0;
	localparam int green_lo = 8;
	localparam int blue_lo = 16;

endpackage

/* testbench/tb_video_mem.sv */
// ======================================================================
// Testbench for the dual-display video memory
// Fills the RAM through the CPU port, runs one scaled HDMI field and a
// full LCD field with back-pressure, checked by concurrent assertions
// ======================================================================

module tb_video_mem;
	timeunit 1ns;
	timeprecision 1ps;
	import video_pkg::*;

	localparam int aw = 11;
	localparam int depth = 1 << aw;
	localparam int ring = 1 << (aw - col_bits);
	localparam int lcd_total = lcd_width * lcd_height + 600;

	// Watchdog budget in ns from the scheduled strobes of each phase
	localparam longint cpu_cycles = depth + 64 + 20;
	localparam longint hdmi_cycles = 480 * 641 + 20;
	localparam longint wd_ns = cpu_cycles * 4 + hdmi_cycles * 6 + lcd_total * 8 + 100000;

	logic clk = 1'b0;
	logic pixel_clk = 1'b0;
	logic reset;
	logic [aw-1:0] addr;
	logic [pixel_w-1:0] data_in;
	logic wen;
	logic ren;
	logic [pixel_w-1:0] data_out;
	logic lcd_next_pixel;
	logic lcd_newfield;
	logic lcd_wait;
	logic [7:0] lcd_red, lcd_green, lcd_blue;
	logic fetch_next;
	logic next_line;
	logic next_field;
	logic [7:0] red, green, blue;

	// Reference memory and the expected words one read later
	logic [pixel_w-1:0] mem_model [depth];
	logic [pixel_w-1:0] exp_hdmi, exp_lcd, rd_exp;
	logic rd_v = 1'b0;
	integer seed = 32'hfcbf_0976;

	// Model of the HDMI position and of the LCD walker
	int h_row, h_col, h_x, h_y, h_line;
	int l_row, l_col, l_line, l_acc;
	logic m_wait, m_newf, l_hold;

	// Check enables, and a window where the row crossing is still settling
	logic hdmi_chk = 1'b0;
	logic lcd_chk = 1'b0;
	logic settling = 1'b0;
	int cpu_errs = 0;
	int hdmi_errs = 0;
	int lcd_errs = 0;
	int nf_count = 0;

	video_mem #(.addr_width(aw)) uut (.*);

	initial forever #2 clk = ~clk;
	initial forever #3 pixel_clk = ~pixel_clk;

	// Reader of the HDMI row is trusted to see it once the crossing settles
	assign l_hold = ((h_row % ring) == l_row) && (l_col == lcd_width - 1);

	// Scaler model, next_field first, then next_line, then fetch_next
	always @(posedge pixel_clk) begin
		exp_hdmi <= mem_model[(h_row % ring) * 512 + h_col];
		if (reset || next_field) begin
			h_row <= 0;
			h_col <= 0;
			h_x <= 0;
			h_y <= 0;
			h_line <= 0;
		end else if (next_line) begin
			h_col <= 0;
			h_x <= 0;
			h_y <= (h_y == y_period - 1) ? 0 : h_y + 1;
			if (h_y < y_keep && h_line != lcd_height - 1) begin
				h_row <= h_row + 1;
				h_line <= h_line + 1;
			end
		end else if (fetch_next) begin
			h_x <= (h_x == x_period - 1) ? 0 : h_x + 1;
			if (h_x < x_keep && h_col != lcd_width - 1) h_col <= h_col + 1;
		end
	end

	// LCD walker model and CPU read expectation
	always @(posedge clk) begin
		rd_v <= ren && !reset;
		rd_exp <= mem_model[addr];
		exp_lcd <= mem_model[l_row * 512 + l_col];
		if (lcd_newfield) nf_count <= nf_count + 1;
		if (reset) begin
			l_row <= 0;
			l_col <= 0;
			l_line <= 0;
			l_acc <= 0;
			m_wait <= 1'b0;
			m_newf <= 1'b0;
		end else begin
			m_wait <= l_hold;
			m_newf <= 1'b0;
			if (lcd_next_pixel && !l_hold && !m_wait) begin
				l_acc <= l_acc + 1;
				if (l_col == lcd_width - 1) begin
					l_col <= 0;
					if (l_line == lcd_height - 1) begin
						l_row <= 0;
						l_line <= 0;
						m_newf <= 1'b1;
					end else begin
						l_row <= (l_row + 1) % ring;
						l_line <= l_line + 1;
					end
				end else begin
					l_col <= l_col + 1;
				end
			end
		end
	end

	a_cpu_read : assert property (@(posedge clk) rd_v |-> data_out == rd_exp)
		else begin
			cpu_errs++;
			$display("[FAIL] data_out %h, expected %h", data_out, rd_exp);
		end

	a_hdmi_pixel : assert property (@(posedge pixel_clk) disable iff (!hdmi_chk)
		{blue, green, red} == exp_hdmi)
		else begin
			hdmi_errs++;
			$display("[FAIL] {blue, green, red} %h, expected %h",
				{blue, green, red}, exp_hdmi);
		end

	// After a field start the picture restarts at address zero
	a_hdmi_field : assert property (@(posedge pixel_clk) disable iff (!hdmi_chk)
		next_field |-> ##2 ({blue, green, red} == mem_model[0]))
		else begin
			hdmi_errs++;
			$display("[FAIL] {blue, green, red} %h after next_field, expected %h",
				{blue, green, red}, mem_model[0]);
		end

	a_lcd_pixel : assert property (@(posedge clk) disable iff (!lcd_chk)
		{lcd_blue, lcd_green, lcd_red} == exp_lcd)
		else begin
			lcd_errs++;
			$display("[FAIL] {lcd_blue, lcd_green, lcd_red} %h, expected %h",
				{lcd_blue, lcd_green, lcd_red}, exp_lcd);
		end

	a_lcd_wait : assert property (@(posedge clk) disable iff (reset || settling)
		lcd_wait == m_wait)
		else begin
			lcd_errs++;
			$display("[FAIL] lcd_wait %h, expected %h", lcd_wait, m_wait);
		end

	a_lcd_hold : assert property (@(posedge clk) disable iff (reset || !lcd_chk)
		lcd_wait |=> $stable({lcd_blue, lcd_green, lcd_red}))
		else begin
			lcd_errs++;
			$display("LCD pixel changed while lcd_wait was high");
		end

	a_lcd_newfield : assert property (@(posedge clk) disable iff (reset)
		lcd_newfield == m_newf)
		else begin
			lcd_errs++;
			$display("[FAIL] lcd_newfield %h, expected %h", lcd_newfield, m_newf);
		end

	a_lcd_field_zero : assert property (@(posedge clk) disable iff (!lcd_chk)
		lcd_newfield |=> ({lcd_blue, lcd_green, lcd_red} == mem_model[0]))
		else begin
			lcd_errs++;
			$display("[FAIL] {lcd_blue, lcd_green, lcd_red} %h after newfield, expected %h",
				{lcd_blue, lcd_green, lcd_red}, mem_model[0]);
		end

	task automatic clk_step();
		@(posedge clk);
		#1;
	endtask

	task automatic pix_step();
		@(posedge pixel_clk);
		#1;
	endtask

	// One raster line: 640 fetches then the line strobe
	task automatic hdmi_line();
		fetch_next = 1'b1;
		repeat (640) pix_step();
		fetch_next = 1'b0;
		next_line = 1'b1;
		pix_step();
		next_line = 1'b0;
	endtask

	// Steps the HDMI side off the LCD row, restarting the field when it has ended
	task automatic move_hdmi_on();
		settling = 1'b1;
		while ((h_row % ring) == l_row) begin
			if (h_line == lcd_height - 1) next_field = 1'b1;
			else next_line = 1'b1;
			pix_step();
			next_field = 1'b0;
			next_line = 1'b0;
			pix_step();
		end
		repeat (8) clk_step();
		settling = 1'b0;
	endtask

	// Requests every cycle; a wait held for three cycles moves the HDMI side on
	task automatic lcd_walk(input int target);
		int held;
		held = 0;
		while (l_acc < target) begin
			if (m_wait && held >= 3) begin
				lcd_next_pixel = 1'b0;
				move_hdmi_on();
				held = 0;
			end else begin
				if (m_wait) held++;
				lcd_next_pixel = 1'b1;
			end
			clk_step();
		end
		lcd_next_pixel = 1'b0;
	endtask

	initial begin
		#(wd_ns);
		$display("Watchdog expired before the tests finished");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [pixel_w-1:0] word;
		reset = 1'b1;
		addr = '0;
		data_in = '0;
		wen = 1'b0;
		ren = 1'b0;
		lcd_next_pixel = 1'b0;
		fetch_next = 1'b0;
		next_line = 1'b0;
		next_field = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// Each word carries its whole address under a random tag
		for (int i = 0; i < depth; i++) begin
			word = {8'($random(seed)), 16'(i)};
			mem_model[i] = word;
			addr = aw'(i);
			data_in = word;
			wen = 1'b1;
			clk_step();
		end
		wen = 1'b0;
		repeat (64) begin
			addr = aw'($random(seed));
			ren = 1'b1;
			clk_step();
		end
		ren = 1'b0;
		repeat (4) clk_step();
		lcd_chk = 1'b1;

		// One scaled HDMI field of 480 raster lines
		repeat (4) pix_step();
		hdmi_chk = 1'b1;
		next_field = 1'b1;
		pix_step();
		next_field = 1'b0;
		repeat (480) hdmi_line();

		// Full LCD field and past the wrap back to address zero
		clk_step();
		lcd_walk(lcd_total);
		repeat (6) clk_step();
		assert (nf_count == 1)
			else begin
				lcd_errs++;
				$display("[FAIL] lcd_newfield pulses %h, expected %h", nf_count, 1);
			end

		$display("Errors: cpu %0d, hdmi %0d, lcd %0d, total %0d", cpu_errs, hdmi_errs,
			lcd_errs, cpu_errs + hdmi_errs + lcd_errs);
		if (cpu_errs + hdmi_errs + lcd_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
